//--- hdl/ethBusPkg.sv
`default_nettype none

package ethBusPkg;

	//////////////////////////////////////////////////////////////////////
	// strobe timing on the controller bus, in clk40m cycles
	//////////////////////////////////////////////////////////////////////

	// wrn low while the address word sits on sd
	localparam int addrStrobeCycles = 10;
	// wrn low while write data sits on sd
	localparam int writeStrobeCycles = 10;
	// rdn low time, controller needs longer to turn the bus around
	localparam int readStrobeCycles = 20;
	// both strobes high between phases and after the data phase
	localparam int turnCycles = 2;

	// phase counter must reach the longest strobe
	localparam int cntWidth = $clog2(readStrobeCycles + 1);

	//////////////////////////////////////////////////////////////////////
	// lane rule for the address word
	//////////////////////////////////////////////////////////////////////

	// first byte-lane enable bit
	localparam int laneBase = 12;
	// four lanes per 32-bit register slot
	localparam int laneCount = 4;

	//////////////////////////////////////////////////////////////////////
	// shared types
	//////////////////////////////////////////////////////////////////////

	// host side data word
	typedef logic [15:0] regData_t;

	typedef logic [cntWidth-1:0] phaseCnt_t;

	// one captured wishbone request
	typedef struct packed {
		logic [7:0] offset;
		logic isWord;
		logic isWrite;
		regData_t wrData;
	} regReq_t;

	// one controller bus transaction
	typedef struct packed {
		logic [15:0] addrWord;
		logic [15:0] dataWord;
		logic isWrite;
		logic isWord;
		logic highByte;
	} busCmd_t;

	// raw bus result plus what the aligner needs
	typedef struct packed {
		logic [15:0] rawData;
		logic isWord;
		logic highByte;
	} busRsp_t;

endpackage

`default_nettype wire

//--- hdl/wbRegPort.sv
`timescale 1ns/1ps
`default_nettype none

module wbRegPort (
	input wire clk40m,
	input wire reset,
	// wishbone classic slave
	input wire wbCyc,
	input wire wbStb,
	input wire wbWe,
	input wire [7:0] wbAdr,
	input wire [1:0] wbSel,
	input wire ethBusPkg::regData_t wbDatW,
	output ethBusPkg::regData_t wbDatR,
	output logic wbAck,
	output logic wbErr,
	// request towards the lane encoder
	output logic reqValid,
	output ethBusPkg::regReq_t req,
	// completion from the read aligner
	input wire rspDone,
	input wire ethBusPkg::regData_t rdData
);

	// one cycle between capture and the err or issue decision
	logic pending;
	logic badReq;
	logic newReq;

	// a request open on the bus that we have not taken yet
	// ack and err terms mask the cycle where the host still holds stb
	assign newReq = wbCyc && wbStb && !pending && !reqValid && !wbAck && !wbErr;

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk40m or negedge reset) begin
		if (!reset) begin
			pending <= 1'b0;
			reqValid <= 1'b0;
			wbAck <= 1'b0;
			wbErr <= 1'b0;
		end else begin
			// ack and err are single pulses
			wbAck <= 1'b0;
			wbErr <= 1'b0;
			if (newReq) begin
				pending <= 1'b1;
			end else if (pending) begin
				pending <= 1'b0;
				// bad requests never reach the bus
				if (badReq) begin
					wbErr <= 1'b1;
				end else begin
					reqValid <= 1'b1;
				end
			end else if (reqValid && rspDone) begin
				reqValid <= 1'b0;
				wbAck <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk40m) begin
		if (newReq) begin
			// high byte lane forces an odd byte offset
			req.offset <= {wbAdr[7:1], wbAdr[0] | (wbSel == 2'b10)};
			req.isWord <= (wbSel == 2'b11);
			req.isWrite <= wbWe;
			req.wrData <= wbDatW;
			// no lanes at all, or a word that straddles a 16-bit boundary
			badReq <= (wbSel == 2'b00) || ((wbSel == 2'b11) && wbAdr[0]);
		end
		// read result lines up with the ack pulse
		if (reqValid && rspDone) begin
			wbDatR <= rdData;
		end
	end

endmodule

`default_nettype wire

//--- hdl/laneEncode.sv
`timescale 1ns/1ps
`default_nettype none

module laneEncode (
	input wire clk40m,
	input wire reset,
	input wire reqValid,
	input wire ethBusPkg::regReq_t req,
	input wire rspDone,
	output logic cmdValid,
	output ethBusPkg::busCmd_t cmd
);

	logic [1:0] lanePos;
	logic [ethBusPkg::laneCount-1:0] laneEn;
	ethBusPkg::busCmd_t nextCmd;
	// set once the current request has gone to the sequencer
	logic issued;

	assign lanePos = req.offset[1:0];

	//////////////////////////////////////////////////////////////////////
	// byte lanes and data placement
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// lane 0 for anything at the slot start
		laneEn[0] = (lanePos == 2'd0);
		// lane 1 for byte 1 or upper half of word 0
		laneEn[1] = (!req.isWord && lanePos == 2'd1) || (req.isWord && lanePos == 2'd0);
		laneEn[2] = (lanePos == 2'd2);
		// lane 3 for byte 3 or upper half of word 2
		laneEn[3] = (!req.isWord && lanePos == 2'd3) || (req.isWord && lanePos == 2'd2);

		nextCmd.addrWord = '0;
		nextCmd.addrWord[ethBusPkg::laneBase +: ethBusPkg::laneCount] = laneEn;
		// slot address, lanes replace bits 1:0
		nextCmd.addrWord[7:2] = req.offset[7:2];

		// byte data comes from the host low byte
		// odd offsets ride on the upper bus half
		nextCmd.highByte = req.offset[0] && !req.isWord;
		if (req.isWord) begin
			nextCmd.dataWord = req.wrData;
		end else if (req.offset[0]) begin
			nextCmd.dataWord = {req.wrData[7:0], 8'h00};
		end else begin
			nextCmd.dataWord = {8'h00, req.wrData[7:0]};
		end
		nextCmd.isWrite = req.isWrite;
		nextCmd.isWord = req.isWord;
	end

	//////////////////////////////////////////////////////////////////////
	// one command pulse per request
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk40m or negedge reset) begin
		if (!reset) begin
			cmdValid <= 1'b0;
			issued <= 1'b0;
		end else begin
			cmdValid <= 1'b0;
			// rearm when the bus cycle is complete
			if (rspDone) begin
				issued <= 1'b0;
			end else if (reqValid && !issued) begin
				cmdValid <= 1'b1;
				issued <= 1'b1;
			end
		end
	end

	// held stable until the next request is taken
	always_ff @(posedge clk40m) begin
		if (reqValid && !issued && !rspDone) begin
			cmd <= nextCmd;
		end
	end

endmodule

`default_nettype wire

//--- hdl/busSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module busSequencer (
	input wire clk40m,
	input wire reset,
	input wire cmdValid,
	input wire ethBusPkg::busCmd_t cmd,
	// controller strobes
	output logic cmdN,
	output logic rdN,
	output logic wrN,
	// split data bus with the pad outside
	output logic [15:0] sdOut,
	output logic sdOe,
	input wire [15:0] sdIn,
	// result towards the read aligner
	output logic rspValid,
	output ethBusPkg::busRsp_t rsp
);

	typedef enum logic [2:0] {
		idle,
		addrStrobe,
		addrTurn,
		dataStrobe,
		dataTurn
	} phase_t;

	phase_t state;
	ethBusPkg::phaseCnt_t phaseCount;
	ethBusPkg::phaseCnt_t phaseLast;
	logic phaseDone;
	// transaction latched for the whole bus cycle
	ethBusPkg::busCmd_t curCmd;
	logic [15:0] rawData;

	//////////////////////////////////////////////////////////////////////
	// phase length
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			addrStrobe: phaseLast = ethBusPkg::phaseCnt_t'(ethBusPkg::addrStrobeCycles - 1);
			addrTurn: phaseLast = ethBusPkg::phaseCnt_t'(ethBusPkg::turnCycles - 1);
			dataStrobe: begin
				// read strobe is longer than write
				if (curCmd.isWrite) begin
					phaseLast = ethBusPkg::phaseCnt_t'(ethBusPkg::writeStrobeCycles - 1);
				end else begin
					phaseLast = ethBusPkg::phaseCnt_t'(ethBusPkg::readStrobeCycles - 1);
				end
			end
			dataTurn: phaseLast = ethBusPkg::phaseCnt_t'(ethBusPkg::turnCycles - 1);
			default: phaseLast = '0;
		endcase
	end

	// last cycle of the current phase
	assign phaseDone = (state != idle) && (phaseCount == phaseLast);

	//////////////////////////////////////////////////////////////////////
	// strobe state machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk40m or negedge reset) begin
		if (!reset) begin
			state <= idle;
			phaseCount <= '0;
			cmdN <= 1'b0;
			rdN <= 1'b1;
			wrN <= 1'b1;
			sdOe <= 1'b0;
			rspValid <= 1'b0;
		end else begin
			rspValid <= 1'b0;
			if (state == idle || phaseDone) begin
				phaseCount <= '0;
			end else begin
				phaseCount <= phaseCount + ethBusPkg::phaseCnt_t'(1);
			end
			case (state)
				idle: begin
					// address word out, cmd high, wrn falls
					if (cmdValid) begin
						cmdN <= 1'b1;
						wrN <= 1'b0;
						sdOe <= 1'b1;
						state <= addrStrobe;
					end
				end
				addrStrobe: begin
					if (phaseDone) begin
						wrN <= 1'b1;
						state <= addrTurn;
					end
				end
				addrTurn: begin
					// cmd drops for the data phase
					if (phaseDone) begin
						cmdN <= 1'b0;
						if (curCmd.isWrite) begin
							wrN <= 1'b0;
						end else begin
							// controller drives sd during rdn
							sdOe <= 1'b0;
							rdN <= 1'b0;
						end
						state <= dataStrobe;
					end
				end
				dataStrobe: begin
					if (phaseDone) begin
						wrN <= 1'b1;
						rdN <= 1'b1;
						state <= dataTurn;
					end
				end
				dataTurn: begin
					// write data held past wrn rise, then released
					if (phaseDone) begin
						sdOe <= 1'b0;
						rspValid <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus data
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk40m) begin
		if (state == idle && cmdValid) begin
			curCmd <= cmd;
			sdOut <= cmd.addrWord;
		end else if (state == addrTurn && phaseDone && curCmd.isWrite) begin
			sdOut <= curCmd.dataWord;
		end
		// sample at the end of the last rdn low cycle
		if (state == dataStrobe && phaseDone && !curCmd.isWrite) begin
			rawData <= sdIn;
		end
	end

	always_comb begin
		rsp.rawData = rawData;
		rsp.isWord = curCmd.isWord;
		rsp.highByte = curCmd.highByte;
	end

endmodule

`default_nettype wire

//--- hdl/readAlign.sv
`timescale 1ns/1ps
`default_nettype none

module readAlign (
	input wire ethBusPkg::busRsp_t rsp,
	input wire rspValid,
	output ethBusPkg::regData_t rdData,
	output logic rspDone
);

	// byte picked from the raw bus word
	logic [7:0] laneByte;

	//////////////////////////////////////////////////////////////////////
	// byte select and zero extension
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// odd byte offsets come back on the upper half
		if (rsp.highByte) begin
			laneByte = rsp.rawData[15:8];
		end else begin
			laneByte = rsp.rawData[7:0];
		end

		// words pass straight through
		// bytes land in the low half with the top cleared
		if (rsp.isWord) begin
			rdData = rsp.rawData;
		end else begin
			rdData = {8'h00, laneByte};
		end
	end

	// same cycle completion towards the wishbone port
	assign rspDone = rspValid;

endmodule

`default_nettype wire

//--- hdl/ethBusTop.sv
`timescale 1ns/1ps
`default_nettype none

module ethBusTop (
	input wire clk40m,
	input wire reset,
	// host wishbone slave
	input wire wbCyc,
	input wire wbStb,
	input wire wbWe,
	input wire [7:0] wbAdr,
	input wire [1:0] wbSel,
	input wire ethBusPkg::regData_t wbDatW,
	output ethBusPkg::regData_t wbDatR,
	output logic wbAck,
	output logic wbErr,
	// controller bus
	output logic cmdN,
	output logic rdN,
	output logic wrN,
	output logic [15:0] sdOut,
	output logic sdOe,
	input wire [15:0] sdIn
);

	//////////////////////////////////////////////////////////////////////
	// stage links
	//////////////////////////////////////////////////////////////////////

	// request path
	wire reqValid;
	ethBusPkg::regReq_t req;
	wire cmdValid;
	ethBusPkg::busCmd_t cmd;
	// response path
	wire rspValid;
	ethBusPkg::busRsp_t rsp;
	wire rspDone;
	ethBusPkg::regData_t rdData;

	// host request capture and ack
	wbRegPort regPort (
		.clk40m(clk40m), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbSel(wbSel),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .wbErr(wbErr),
		.reqValid(reqValid), .req(req), .rspDone(rspDone), .rdData(rdData)
	);

	// lane enables and data placement
	laneEncode encoder (
		.clk40m(clk40m), .reset(reset),
		.reqValid(reqValid), .req(req), .rspDone(rspDone),
		.cmdValid(cmdValid), .cmd(cmd)
	);

	// address and data phases on the controller bus
	busSequencer sequencer (
		.clk40m(clk40m), .reset(reset),
		.cmdValid(cmdValid), .cmd(cmd),
		.cmdN(cmdN), .rdN(rdN), .wrN(wrN),
		.sdOut(sdOut), .sdOe(sdOe), .sdIn(sdIn),
		.rspValid(rspValid), .rsp(rsp)
	);

	// return byte or word to the host
	readAlign aligner (
		.rsp(rsp), .rspValid(rspValid),
		.rdData(rdData), .rspDone(rspDone)
	);

endmodule

`default_nettype wire

//--- dv/ethChipModel.sv
`timescale 1ns/1ps
`default_nettype none

module ethChipModel (
	input wire reset,
	input wire cmdN,
	input wire rdN,
	input wire wrN,
	input wire [15:0] sdOut,
	input wire sdOe,
	output logic [15:0] sdIn,
	output logic fault
);

	// 256-byte register space of the controller
	logic [7:0] regs [256];
	logic [15:0] addrWord;
	// next wrn strobe belongs to an address phase
	logic expectAddr;
	logic lastRd;
	logic lastWr;
	logic faultSeen = 1'b0;
	logic [7:0] pairBase;

	assign fault = faultSeen;

	task automatic raiseFault(input string why);
		$display("chip model: %s", why);
		faultSeen = 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////////////////////////

	// upper lanes 2 and 3 select the upper byte pair
	assign pairBase = {addrWord[7:2], addrWord[ethBusPkg::laneBase + 2] |
		addrWord[ethBusPkg::laneBase + 3], 1'b0};
	// odd byte on the high half, even byte on the low half
	assign sdIn = rdN ? 16'h0000 : {regs[pairBase + 8'd1], regs[pairBase]};

	//////////////////////////////////////////////////////////////////////
	// strobe protocol and writes
	//////////////////////////////////////////////////////////////////////

	initial begin
		// fill depends on the whole byte offset
		for (int i = 0; i < 256; i++) begin
			regs[i] = 8'(i) ^ 8'h96;
		end
		expectAddr = 1'b1;
		addrWord = '0;
		lastRd = 1'b1;
		lastWr = 1'b1;
		forever begin
			@(rdN or wrN);
			if (reset === 1'b1) begin
				if (rdN === 1'b0 && wrN === 1'b0) begin
					raiseFault("RDN and WRN are low at the same time");
				end
				// wrn rise closes either an address or a write strobe
				if (wrN === 1'b1 && lastWr === 1'b0) begin
					if (expectAddr) begin
						if (cmdN !== 1'b1 || sdOe !== 1'b1) begin
							raiseFault("CMD or sdOe not high during the address strobe");
						end
						addrWord = sdOut;
						expectAddr = 1'b0;
					end else begin
						// even lanes from the low half, odd lanes from the high half
						for (int lane = 0; lane < 4; lane++) begin
							if (addrWord[ethBusPkg::laneBase + lane]) begin
								if (lane % 2 == 0) begin
									regs[{addrWord[7:2], 2'(lane)}] = sdOut[7:0];
								end else begin
									regs[{addrWord[7:2], 2'(lane)}] = sdOut[15:8];
								end
							end
						end
						expectAddr = 1'b1;
					end
				end
				if (rdN === 1'b0 && lastRd === 1'b1 && expectAddr) begin
					raiseFault("RDN fell without an address phase before it");
				end
				// rdn rise ends a read cycle
				if (rdN === 1'b1 && lastRd === 1'b0) begin
					expectAddr = 1'b1;
				end
			end
			lastRd = rdN;
			lastWr = wrN;
		end
	end

endmodule

`default_nettype wire

//--- dv/tbEthBus.sv
`timescale 1ns/1ps
`default_nettype none

module tbEthBus;

	localparam int driveSkew = 2;
	localparam int ackTimeout = 200;
	localparam int tableRows = 14;
	localparam int randomRuns = 40;

	// one directed access and what it should give back
	typedef struct packed {
		logic [95:0] name;
		logic isWrite;
		logic [7:0] adr;
		logic [1:0] sel;
		ethBusPkg::regData_t data;
		ethBusPkg::regData_t expData;
		logic expErr;
	} stimRow_t;

	logic clk40m;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [7:0] wbAdr;
	logic [1:0] wbSel;
	ethBusPkg::regData_t wbDatW;
	ethBusPkg::regData_t wbDatR;
	logic wbAck;
	logic wbErr;
	logic cmdN;
	logic rdN;
	logic wrN;
	logic [15:0] sdOut;
	logic sdOe;
	logic [15:0] sdIn;
	logic fault;

	stimRow_t stimTable [tableRows];
	// expected register contents
	logic [7:0] shadow [256];
	int strobeFalls = 0;

	ethBusTop uut (
		.clk40m(clk40m), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbSel(wbSel),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .wbErr(wbErr),
		.cmdN(cmdN), .rdN(rdN), .wrN(wrN), .sdOut(sdOut), .sdOe(sdOe), .sdIn(sdIn)
	);

	ethChipModel chip (
		.reset(reset), .cmdN(cmdN), .rdN(rdN), .wrN(wrN),
		.sdOut(sdOut), .sdOe(sdOe), .sdIn(sdIn), .fault(fault)
	);

	initial begin
		clk40m = 1'b0;
		forever #20 clk40m = ~clk40m;
	end

	// any falling strobe counts as bus activity
	always @(negedge wrN or negedge rdN) begin
		if (reset) begin
			strobeFalls = strobeFalls + 1;
		end
	end

	always @(posedge fault) begin
		failRun("protocol check in the chip model failed");
	end

	//////////////////////////////////////////////////////////////////////
	// reporting and compares
	//////////////////////////////////////////////////////////////////////

	task automatic failRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkData(input string name, input ethBusPkg::regData_t expVal,
		input ethBusPkg::regData_t actVal);
		if (actVal !== expVal) begin
			failRun($sformatf("ERR %s expected %h actual %h", name, expVal, actVal));
		end
	endtask

	task automatic checkErr(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			failRun($sformatf("ERR %s expected %b actual %b", name, expVal, actVal));
		end
	endtask

	// idle pin levels on the controller side
	task automatic checkLevel(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			failRun($sformatf("ERR %s expected %b actual %b", name, expVal, actVal));
		end
	endtask

	// strip the zero padding of a packed name
	function automatic string rowName(input logic [95:0] raw);
		string s = "";
		for (int i = 11; i >= 0; i--) begin
			if (raw[i*8 +: 8] != 8'h00) begin
				s = $sformatf("%s%c", s, raw[i*8 +: 8]);
			end
		end
		return s;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// shadow model of the lane rules
	//////////////////////////////////////////////////////////////////////

	// high byte lane makes the offset odd
	function automatic logic [7:0] offsetOf(input logic [7:0] adr, input logic [1:0] sel);
		if (sel == 2'b10) begin
			return adr | 8'h01;
		end
		return adr;
	endfunction

	task automatic shadowWrite(input logic [7:0] offset, input logic isWord,
		input ethBusPkg::regData_t data);
		shadow[offset] = data[7:0];
		if (isWord) begin
			shadow[offset + 8'd1] = data[15:8];
		end
	endtask

	function automatic ethBusPkg::regData_t shadowRead(input logic [7:0] offset,
		input logic isWord);
		if (isWord) begin
			return {shadow[offset + 8'd1], shadow[offset]};
		end
		return {8'h00, shadow[offset]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// wishbone host
	//////////////////////////////////////////////////////////////////////

	task automatic busAccess(input logic isWrite, input logic [7:0] adr, input logic [1:0] sel,
		input ethBusPkg::regData_t data, output ethBusPkg::regData_t rdVal,
		output logic gotAck, output logic gotErr);
		int waited;
		@(posedge clk40m);
		#driveSkew;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = isWrite;
		wbAdr = adr;
		wbSel = sel;
		wbDatW = data;
		rdVal = '0;
		gotAck = 1'b0;
		gotErr = 1'b0;
		waited = 0;
		// sample mid cycle, away from the edge
		while (!gotAck && !gotErr) begin
			@(negedge clk40m);
			gotAck = wbAck;
			gotErr = wbErr;
			rdVal = wbDatR;
			waited++;
			if (!gotAck && !gotErr && waited >= ackTimeout) begin
				failRun("no ack or err came back from the DUT in time");
			end
		end
		@(posedge clk40m);
		#driveSkew;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic runRow(input stimRow_t row);
		string name;
		int fallsBefore;
		ethBusPkg::regData_t rdVal;
		logic gotAck;
		logic gotErr;
		name = rowName(row.name);
		fallsBefore = strobeFalls;
		busAccess(row.isWrite, row.adr, row.sel, row.data, rdVal, gotAck, gotErr);
		checkErr(name, row.expErr, gotErr);
		checkErr({name, "Ack"}, !row.expErr, gotAck);
		if (row.expErr) begin
			// a bus cycle started with the err would strobe within two edges
			repeat (2) @(posedge clk40m);
			#driveSkew;
			// rejected requests must stay off the bus
			if (strobeFalls != fallsBefore) begin
				failRun($sformatf("%s moved a strobe on the controller bus", name));
			end
		end else if (row.isWrite) begin
			shadowWrite(offsetOf(row.adr, row.sel), row.sel == 2'b11, row.data);
		end else begin
			checkData(name, row.expData, rdVal);
		end
	endtask

	task automatic loadTable();
		// name, write, adr, sel, data, expected data, expected err
		stimTable[0] = '{"wordWr8", 1'b1, 8'h08, 2'b11, 16'hbeef, 16'h0000, 1'b0};
		stimTable[1] = '{"wordRd8", 1'b0, 8'h08, 2'b11, 16'h0000, 16'hbeef, 1'b0};
		stimTable[2] = '{"wordWr2", 1'b1, 8'h02, 2'b11, 16'h1234, 16'h0000, 1'b0};
		stimTable[3] = '{"wordRd2", 1'b0, 8'h02, 2'b11, 16'h0000, 16'h1234, 1'b0};
		stimTable[4] = '{"byteWr4", 1'b1, 8'h04, 2'b01, 16'hffa5, 16'h0000, 1'b0};
		// high lane select at an even address lands on offset 5
		stimTable[5] = '{"byteWr5", 1'b1, 8'h04, 2'b10, 16'h003c, 16'h0000, 1'b0};
		stimTable[6] = '{"wordRd4", 1'b0, 8'h04, 2'b11, 16'h0000, 16'h3ca5, 1'b0};
		stimTable[7] = '{"byteRd5", 1'b0, 8'h05, 2'b01, 16'h0000, 16'h003c, 1'b0};
		stimTable[8] = '{"byteRd5hi", 1'b0, 8'h04, 2'b10, 16'h0000, 16'h003c, 1'b0};
		stimTable[9] = '{"byteWr3", 1'b1, 8'h03, 2'b01, 16'h0077, 16'h0000, 1'b0};
		stimTable[10] = '{"byteRd3", 1'b0, 8'h03, 2'b01, 16'h0000, 16'h0077, 1'b0};
		stimTable[11] = '{"oddWordWr", 1'b1, 8'h09, 2'b11, 16'hdead, 16'h0000, 1'b1};
		stimTable[12] = '{"selZeroRd", 1'b0, 8'h08, 2'b00, 16'h0000, 16'h0000, 1'b1};
		stimTable[13] = '{"wordRd8b", 1'b0, 8'h08, 2'b11, 16'h0000, 16'hbeef, 1'b0};
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		string name;
		logic isWrite;
		logic [7:0] adr;
		logic [1:0] sel;
		logic [7:0] offset;
		ethBusPkg::regData_t data;
		ethBusPkg::regData_t rdVal;
		logic gotAck;
		logic gotErr;
		void'($urandom(32'hc0aa));
		reset = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = 8'h00;
		wbSel = 2'b00;
		wbDatW = '0;
		loadTable();
		// same fill as the chip model powers up with
		for (int i = 0; i < 256; i++) begin
			shadow[i] = 8'(i) ^ 8'h96;
		end
		repeat (16) @(posedge clk40m);
		#driveSkew;
		reset = 1'b1;

		// quiet bus before the first request
		@(negedge clk40m);
		checkLevel("idleCmd", 1'b0, cmdN);
		checkLevel("idleRdN", 1'b1, rdN);
		checkLevel("idleWrN", 1'b1, wrN);
		checkLevel("idleSdOe", 1'b0, sdOe);
		checkErr("idleAck", 1'b0, wbAck);
		checkErr("idleErr", 1'b0, wbErr);

		for (int i = 0; i < tableRows; i++) begin
			runRow(stimTable[i]);
		end

		// mixed legal accesses against the shadow bytes
		for (int n = 0; n < randomRuns; n++) begin
			name = $sformatf("rand%0d", n);
			isWrite = 1'($urandom);
			sel = 2'($urandom % 3) + 2'd1;
			adr = 8'($urandom);
			if (sel == 2'b11) begin
				adr[0] = 1'b0;
			end
			data = 16'($urandom);
			offset = offsetOf(adr, sel);
			busAccess(isWrite, adr, sel, data, rdVal, gotAck, gotErr);
			checkErr(name, 1'b0, gotErr);
			if (isWrite) begin
				shadowWrite(offset, sel == 2'b11, data);
			end else begin
				checkData(name, shadowRead(offset, sel == 2'b11), rdVal);
			end
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hdl/ethBusPkg.sv
hdl/wbRegPort.sv
hdl/laneEncode.sv
hdl/busSequencer.sv
hdl/readAlign.sv
hdl/ethBusTop.sv
dv/ethChipModel.sv
dv/tbEthBus.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tbEthBus -f list.f -o simEthBus

# a fatal check exits non-zero, the log decides the result
./obj_dir/simEthBus > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
